/* hdl/alu_adder.sv */
`timescale 1ns/1ps

module alu_adder (
	input  logic [7:0] a,
	input  logic [7:0] b,		// Already complemented for subtract
	input  logic       carry_in,
	output logic [7:0] sum,
	output logic       half_carry,	// Out of bit 3
	output logic       carry_out	// Out of bit 7
);

	logic [7:0] gen;		// Generate terms
	logic [7:0] prop;		// Propagate terms, also half sums
	logic [3:0] carry_lo;	// Carries out of bits 3..0
	logic [3:0] carry_hi;	// Carries out of bits 7..4
	logic [7:0] carry_vec;	// Carry into each bit

	// Lookahead for one nibble group, all four carries from g, p and ci
	function automatic logic [3:0] cla4(
		input logic [3:0] g,
		input logic [3:0] p,
		input logic       ci
	);
		logic [3:0] c;
		c[0] = g[0] | (p[0] & ci);
		c[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & ci);
		c[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & ci);
		c[3] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0])
			| (p[3] & p[2] & p[1] & p[0] & ci);
		return c;
	endfunction

	assign gen  = a & b;
	assign prop = a ^ b;

	assign carry_lo = cla4(gen[3:0], prop[3:0], carry_in);
	assign carry_hi = cla4(gen[7:4], prop[7:4], carry_lo[3]);	// Ripple between groups

	assign carry_vec = {carry_hi[2:0], carry_lo, carry_in};
	assign sum       = prop ^ carry_vec;

	assign half_carry = carry_lo[3];	// Nibble boundary
	assign carry_out  = carry_hi[3];

endmodule

/* hdl/alu_core.sv */
`timescale 1ns/1ps

// Unary ops (INC, DEC, shifts, DAA, CPL, BIT, SET, RES) work on operand A
module alu_core (
	input  logic                clk,
	input  logic                arst_n,
	input  logic [7:0]          op_a,
	input  logic [7:0]          op_b,
	input  alu_pkg::alu_ctrl_t  ctrl,
	input  logic                launch,		// One cycle, loads result and flags
	input  logic                flags_wr,		// Direct flag load from the bus
	input  alu_pkg::alu_flags_t flags_wdata,
	input  alu_pkg::alu_cond_e  cond,
	output logic [7:0]          result,
	output alu_pkg::alu_flags_t flags,
	output logic                cond_taken
);

	logic [7:0]          bit_mask;		// One-hot from bit_idx
	logic [7:0]          a_prep;		// A after SET/RES mask
	logic [7:0]          b_src;		// B, constant 1 or DAA value
	logic                b_cpl;		// Invert adder B
	logic [7:0]          add_b;
	logic                add_cin;
	logic [7:0]          add_sum;
	logic                add_hc;
	logic                add_co;
	logic [7:0]          shift_res;
	logic                shift_co;
	logic [7:0]          logic_res;		// Logic ops and pass-through
	logic [7:0]          result_d;
	alu_pkg::alu_flags_t next_flags;
	logic                flag_we_c;
	logic                flag_we_znh;
	logic [7:0]          daa_adjust;

	assign bit_mask = 8'h01 << ctrl.bit_idx;

	always_comb begin
		case (ctrl.op)
			alu_pkg::SET: a_prep = op_a | bit_mask;
			alu_pkg::RES: a_prep = op_a & ~bit_mask;
			default:      a_prep = op_a;
		endcase
	end

	// Subtract is A + ~B with inverted carry in
	always_comb begin
		b_src   = op_b;
		b_cpl   = 1'b0;
		add_cin = 1'b0;
		case (ctrl.op)
			alu_pkg::ADC: add_cin = flags.c;
			alu_pkg::SUB, alu_pkg::CP: begin
				b_cpl   = 1'b1;
				add_cin = 1'b1;
			end
			alu_pkg::SBC: begin
				b_cpl   = 1'b1;
				add_cin = ~flags.c;
			end
			alu_pkg::INC: b_src = 8'h01;
			alu_pkg::DEC: begin
				b_src   = 8'h01;
				b_cpl   = 1'b1;
				add_cin = 1'b1;
			end
			alu_pkg::DAA: begin			// Direction follows N
				b_src   = daa_adjust;
				b_cpl   = flags.n;
				add_cin = flags.n;
			end
			default: ;
		endcase
	end

	assign add_b = b_cpl ? ~b_src : b_src;

	alu_adder alu_adder_i (
		.a          (op_a),
		.b          (add_b),
		.carry_in   (add_cin),
		.sum        (add_sum),
		.half_carry (add_hc),
		.carry_out  (add_co)
	);

	alu_shifter alu_shifter_i (
		.operand   (op_a),
		.op        (ctrl.op),
		.carry     (flags.c),
		.result    (shift_res),
		.carry_out (shift_co)
	);

	always_comb begin
		case (ctrl.op)
			alu_pkg::AND: logic_res = a_prep & op_b;
			alu_pkg::OR:  logic_res = a_prep | op_b;
			alu_pkg::XOR: logic_res = a_prep ^ op_b;
			alu_pkg::CPL: logic_res = ~a_prep;
			default:      logic_res = a_prep;		// CP, SCF, CCF, BIT, SET, RES
		endcase
	end

	always_comb begin
		case (ctrl.op)
			alu_pkg::ADD, alu_pkg::ADC, alu_pkg::SUB, alu_pkg::SBC,
			alu_pkg::INC, alu_pkg::DEC, alu_pkg::DAA:
				result_d = add_sum;
			alu_pkg::RLC, alu_pkg::RRC, alu_pkg::RL, alu_pkg::RR,
			alu_pkg::SLA, alu_pkg::SRA, alu_pkg::SRL, alu_pkg::SWAP:
				result_d = shift_res;
			default:
				result_d = logic_res;
		endcase
	end

	alu_flag_logic alu_flag_logic_i (
		.op          (ctrl.op),
		.bit_idx     (ctrl.bit_idx),
		.flags       (flags),
		.op_a        (op_a),
		.op_b        (op_b),
		.result      (result_d),
		.half_carry  (add_hc),
		.carry_out   (add_co),
		.shift_carry (shift_co),
		.cond        (cond),
		.next_flags  (next_flags),
		.flag_we_c   (flag_we_c),
		.flag_we_znh (flag_we_znh),
		.daa_adjust  (daa_adjust),
		.daa_carry   (),
		.cond_taken  (cond_taken)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result <= '0;
		end else if (launch) begin
			result <= result_d;
		end
	end

	// C has its own enable, Z/N/H share one
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
		end else if (flags_wr) begin
			flags <= flags_wdata;
		end else if (launch) begin
			if (flag_we_c) begin
				flags.c <= next_flags.c;
			end
			if (flag_we_znh) begin
				flags.z <= next_flags.z;
				flags.n <= next_flags.n;
				flags.h <= next_flags.h;
			end
		end
	end

	a_one_writer: assert property (@(posedge clk) disable iff (!arst_n)
		!(launch && flags_wr))
		else $error("Launch and flag write in the same cycle");

endmodule

/* hdl/alu_flag_logic.sv */
`timescale 1ns/1ps

module alu_flag_logic (
	input  alu_pkg::alu_op_e    op,
	input  logic [2:0]          bit_idx,
	input  alu_pkg::alu_flags_t flags,			// Registered flags
	input  logic [7:0]          op_a,
	input  logic [7:0]          op_b,
	input  logic [7:0]          result,			// Unregistered result
	input  logic                half_carry,
	input  logic                carry_out,
	input  logic                shift_carry,
	input  alu_pkg::alu_cond_e  cond,
	output alu_pkg::alu_flags_t next_flags,
	output logic                flag_we_c,
	output logic                flag_we_znh,
	output logic [7:0]          daa_adjust,		// Added or subtracted by core
	output logic                daa_carry,
	output logic                cond_taken
);

	logic res_zero;		// Result is zero
	logic cp_zero;		// A equals B, CP keeps A as result
	logic bit_zero;		// Tested bit clear
	logic daa_lo;		// Low nibble needs 06
	logic daa_hi;		// High nibble needs 60

	assign res_zero = (result == 8'h00);
	assign cp_zero  = (op_a == op_b);
	assign bit_zero = ~op_a[bit_idx];

	// DAA correction depends only on A and the flags of the last add or subtract
	assign daa_lo     = flags.h | (~flags.n & (op_a[3:0] > 4'd9));
	assign daa_hi     = flags.c | (~flags.n & (op_a > 8'h99));
	assign daa_adjust = {(daa_hi ? 4'h6 : 4'h0), (daa_lo ? 4'h6 : 4'h0)};
	assign daa_carry  = daa_hi;

	// All flag rules in one place
	always_comb begin
		next_flags  = flags;			// Default keep
		flag_we_c   = 1'b1;
		flag_we_znh = 1'b1;
		case (op)
			alu_pkg::ADD, alu_pkg::ADC:
				next_flags = '{z: res_zero, n: 1'b0, h: half_carry, c: carry_out};
			alu_pkg::SUB, alu_pkg::SBC:
				next_flags = '{z: res_zero, n: 1'b1, h: ~half_carry, c: ~carry_out};	// Borrows
			alu_pkg::CP:
				next_flags = '{z: cp_zero, n: 1'b1, h: ~half_carry, c: ~carry_out};
			alu_pkg::AND:
				next_flags = '{z: res_zero, n: 1'b0, h: 1'b1, c: 1'b0};
			alu_pkg::XOR, alu_pkg::OR:
				next_flags = '{z: res_zero, n: 1'b0, h: 1'b0, c: 1'b0};
			alu_pkg::INC: begin
				next_flags = '{z: res_zero, n: 1'b0, h: half_carry, c: flags.c};
				flag_we_c  = 1'b0;
			end
			alu_pkg::DEC: begin
				next_flags = '{z: res_zero, n: 1'b1, h: ~half_carry, c: flags.c};
				flag_we_c  = 1'b0;
			end
			alu_pkg::RLC, alu_pkg::RRC, alu_pkg::RL, alu_pkg::RR,
			alu_pkg::SLA, alu_pkg::SRA, alu_pkg::SRL, alu_pkg::SWAP:
				next_flags = '{z: res_zero, n: 1'b0, h: 1'b0, c: shift_carry};
			alu_pkg::DAA:
				next_flags = '{z: res_zero, n: flags.n, h: 1'b0, c: daa_carry};	// N kept
			alu_pkg::CPL: begin
				next_flags = '{z: flags.z, n: 1'b1, h: 1'b1, c: flags.c};
				flag_we_c  = 1'b0;
			end
			alu_pkg::SCF:
				next_flags = '{z: flags.z, n: 1'b0, h: 1'b0, c: 1'b1};
			alu_pkg::CCF:
				next_flags = '{z: flags.z, n: 1'b0, h: 1'b0, c: ~flags.c};
			alu_pkg::BIT: begin
				next_flags = '{z: bit_zero, n: 1'b0, h: 1'b1, c: flags.c};
				flag_we_c  = 1'b0;
			end
			default: begin			// SET, RES and unused codes
				flag_we_c   = 1'b0;
				flag_we_znh = 1'b0;
			end
		endcase
	end

	// Jump condition from the stored flags
	always_comb begin
		case (cond)
			alu_pkg::NZ: cond_taken = ~flags.z;
			alu_pkg::Z:  cond_taken = flags.z;
			alu_pkg::NC: cond_taken = ~flags.c;
			default:     cond_taken = flags.c;
		endcase
	end

	// Carry is never written by ops that keep it
	a_c_kept: assert final (!(op inside {alu_pkg::INC, alu_pkg::DEC, alu_pkg::BIT,
		alu_pkg::SET, alu_pkg::RES}) || !flag_we_c)
		else $error("Carry write enable during %s", op.name());

	// Bit set/reset leaves all flags alone
	a_setres_quiet: assert final (!(op inside {alu_pkg::SET, alu_pkg::RES})
		|| !(flag_we_c || flag_we_znh))
		else $error("Flag write enable during %s", op.name());

endmodule

/* hdl/alu_pkg.sv */
`include "alu_settings.svh"

package alu_pkg;

	// SM83 ALU operations, first eight in the order of the 8-bit ALU group
	typedef enum logic [4:0] {
		ADD  = 5'd0,	// A + B
		ADC  = 5'd1,	// A + B + C
		SUB  = 5'd2,	// A - B
		SBC  = 5'd3,	// A - B - C
		AND  = 5'd4,
		XOR  = 5'd5,
		OR   = 5'd6,
		CP   = 5'd7,	// Compare, A kept
		INC  = 5'd8,	// C untouched
		DEC  = 5'd9,	// C untouched
		RLC  = 5'd10,	// Rotate left, bit 7 to C
		RRC  = 5'd11,	// Rotate right, bit 0 to C
		RL   = 5'd12,	// Rotate left through C
		RR   = 5'd13,	// Rotate right through C
		SLA  = 5'd14,	// Shift left, zero in
		SRA  = 5'd15,	// Shift right, sign kept
		SRL  = 5'd16,	// Shift right, zero in
		SWAP = 5'd17,	// Nibble exchange
		DAA  = 5'd18,	// BCD correction of A
		CPL  = 5'd19,	// Complement A
		SCF  = 5'd20,	// Set carry
		CCF  = 5'd21,	// Invert carry
		BIT  = 5'd22,	// Test A[bit_idx]
		SET  = 5'd23,	// A | mask
		RES  = 5'd24	// A & ~mask
	} alu_op_e;

	// Branch conditions, encoded as in the cc field
	typedef enum logic [1:0] {
		NZ = 2'd0,
		Z  = 2'd1,
		NC = 2'd2,
		C  = 2'd3
	} alu_cond_e;

	typedef struct packed {
		logic z;	// Zero
		logic n;	// Subtract
		logic h;	// Half carry
		logic c;	// Carry
	} alu_flags_t;

	typedef struct packed {
		logic [2:0] bit_idx;	// Bit for BIT/SET/RES
		alu_op_e    op;
	} alu_ctrl_t;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [`ALU_WB_ADR_W-1:0] adr;
		logic [`ALU_WB_DAT_W-1:0] dat;
	} wb_m2s_t;

	// Wishbone classic, slave to master
	typedef struct packed {
		logic                     ack;
		logic [`ALU_WB_DAT_W-1:0] dat;
	} wb_s2m_t;

endpackage

/* hdl/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Bus widths
`define ALU_WB_ADR_W 3		// Eight register slots
`define ALU_WB_DAT_W 8		// One byte per access

// Register map
`define ALU_ADR_OPA    0	// Operand A, read/write
`define ALU_ADR_OPB    1	// Operand B, read/write
`define ALU_ADR_CTRL   2	// Opcode and bit index, write launches
`define ALU_ADR_RESULT 3	// Registered result, read only
`define ALU_ADR_FLAGS  4	// ZNHC in bits 7..4
`define ALU_ADR_COND   5	// Write condition code, read taken bit

`endif

/* hdl/alu_shifter.sv */
`timescale 1ns/1ps

module alu_shifter (
	input  logic [7:0]       operand,		// Byte to rotate or shift
	input  alu_pkg::alu_op_e op,
	input  logic             carry,		// Flag C, enters on RL and RR
	output logic [7:0]       result,
	output logic             carry_out		// Bit pushed out
);

	logic left_fill;		// Enters at bit 0
	logic right_fill;		// Enters at bit 7

	// Fill bit for left moves
	always_comb begin
		case (op)
			alu_pkg::RLC: left_fill = operand[7];	// Circular
			alu_pkg::RL:  left_fill = carry;		// Through C
			default:      left_fill = 1'b0;		// SLA
		endcase
	end

	// Fill bit for right moves
	always_comb begin
		case (op)
			alu_pkg::RRC: right_fill = operand[0];
			alu_pkg::RR:  right_fill = carry;
			alu_pkg::SRA: right_fill = operand[7];	// Sign extend
			default:      right_fill = 1'b0;		// SRL
		endcase
	end

	always_comb begin
		case (op)
			alu_pkg::RLC, alu_pkg::RL, alu_pkg::SLA: begin
				result    = {operand[6:0], left_fill};
				carry_out = operand[7];
			end
			alu_pkg::RRC, alu_pkg::RR, alu_pkg::SRA, alu_pkg::SRL: begin
				result    = {right_fill, operand[7:1]};
				carry_out = operand[0];
			end
			alu_pkg::SWAP: begin
				result    = {operand[3:0], operand[7:4]};
				carry_out = 1'b0;			// SWAP always clears C
			end
			default: begin
				result    = operand;		// Not selected by the core
				carry_out = 1'b0;
			end
		endcase
	end

endmodule

/* hdl/alu_top.sv */
`timescale 1ns/1ps

module alu_top (
	input  logic             clk,
	input  logic             arst_n,
	input  alu_pkg::wb_m2s_t bus,		// From bus master
	output alu_pkg::wb_s2m_t resp
);

	logic [7:0]          op_a;
	logic [7:0]          op_b;
	alu_pkg::alu_ctrl_t  ctrl;
	logic                launch;
	logic                flags_wr;
	alu_pkg::alu_flags_t flags_wdata;
	alu_pkg::alu_cond_e  cond;
	logic [7:0]          result;		// Registered in the core
	alu_pkg::alu_flags_t flags;
	logic                cond_taken;

	alu_wb_slave alu_wb_slave_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.bus         (bus),
		.result      (result),
		.flags       (flags),
		.cond_taken  (cond_taken),
		.resp        (resp),
		.op_a        (op_a),
		.op_b        (op_b),
		.ctrl        (ctrl),
		.launch      (launch),
		.flags_wr    (flags_wr),
		.flags_wdata (flags_wdata),
		.cond        (cond)
	);

	alu_core alu_core_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.op_a        (op_a),
		.op_b        (op_b),
		.ctrl        (ctrl),
		.launch      (launch),
		.flags_wr    (flags_wr),
		.flags_wdata (flags_wdata),
		.cond        (cond),
		.result      (result),
		.flags       (flags),
		.cond_taken  (cond_taken)
	);

endmodule

/* hdl/alu_wb_slave.sv */
`timescale 1ns/1ps
`include "alu_settings.svh"

module alu_wb_slave (
	input  logic                clk,
	input  logic                arst_n,
	input  alu_pkg::wb_m2s_t    bus,
	input  logic [7:0]          result,
	input  alu_pkg::alu_flags_t flags,
	input  logic                cond_taken,
	output alu_pkg::wb_s2m_t    resp,
	output logic [7:0]          op_a,
	output logic [7:0]          op_b,
	output alu_pkg::alu_ctrl_t  ctrl,
	output logic                launch,		// High with ack of a control write
	output logic                flags_wr,
	output alu_pkg::alu_flags_t flags_wdata,
	output alu_pkg::alu_cond_e  cond
);

	logic                     ack;
	logic                     wr_cyc;		// Write in its ack cycle
	alu_pkg::alu_ctrl_t       ctrl_q;		// Last control written
	logic [`ALU_WB_DAT_W-1:0] rd_data;

	// One wait cycle, then ack for exactly one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= bus.cyc & bus.stb & ~ack;
		end
	end

	assign wr_cyc = ack & bus.we;	// Master holds adr/dat until ack

	assign launch      = wr_cyc & (bus.adr == `ALU_ADR_CTRL);
	assign flags_wr    = wr_cyc & (bus.adr == `ALU_ADR_FLAGS);
	assign flags_wdata = alu_pkg::alu_flags_t'(bus.dat[7:4]);	// Low nibble ignored

	// Core sees the new control during launch, the stored copy otherwise
	assign ctrl = launch ? alu_pkg::alu_ctrl_t'(bus.dat) : ctrl_q;

	// Writes land at the edge that ends ack
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_a   <= '0;
			op_b   <= '0;
			ctrl_q <= '0;
			cond   <= alu_pkg::NZ;
		end else if (wr_cyc) begin
			case (bus.adr)
				`ALU_ADR_OPA:  op_a   <= bus.dat;
				`ALU_ADR_OPB:  op_b   <= bus.dat;
				`ALU_ADR_CTRL: ctrl_q <= alu_pkg::alu_ctrl_t'(bus.dat);
				`ALU_ADR_COND: cond   <= alu_pkg::alu_cond_e'(bus.dat[1:0]);
				default: ;			// Result and flags owned by the core
			endcase
		end
	end

	// Read mux, sampled by the master in the ack cycle
	always_comb begin
		case (bus.adr)
			`ALU_ADR_OPA:    rd_data = op_a;
			`ALU_ADR_OPB:    rd_data = op_b;
			`ALU_ADR_CTRL:   rd_data = ctrl_q;
			`ALU_ADR_RESULT: rd_data = result;
			`ALU_ADR_FLAGS:  rd_data = {flags, 4'h0};
			`ALU_ADR_COND:   rd_data = {7'h00, cond_taken};
			default:         rd_data = '0;
		endcase
	end

	assign resp = '{ack: ack, dat: rd_data};

	a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		ack |=> !ack)
		else $error("Ack held for two cycles");

endmodule

/* list.f */
+incdir+hdl
+incdir+sim
hdl/alu_pkg.sv
hdl/alu_shifter.sv
hdl/alu_adder.sv
hdl/alu_flag_logic.sv
hdl/alu_core.sv
hdl/alu_wb_slave.sv
hdl/alu_top.sv
sim/tb_alu.sv

/* sim/tb_alu_ref.svh */
`ifndef TB_ALU_REF_SVH
`define TB_ALU_REF_SVH

// Expected result and flags of one operation, from the SM83 instruction rules
function automatic void ref_alu(
	input  alu_pkg::alu_op_e    op,
	input  logic [2:0]          idx,
	input  logic [7:0]          a,
	input  logic [7:0]          b,
	input  alu_pkg::alu_flags_t f,		// Flags before the operation
	output logic [7:0]          res,
	output alu_pkg::alu_flags_t fl
);
	int         ai;
	int         bi;
	int         ci;
	int         full;
	logic [7:0] corr;
	ai   = a;
	bi   = b;
	ci   = 0;
	res  = a;		// Pass-through unless changed
	fl   = f;		// Flags kept unless changed
	corr = 8'h00;
	case (op)
		alu_pkg::ADD, alu_pkg::ADC: begin
			if (op == alu_pkg::ADC) ci = f.c;
			full = ai + bi + ci;
			res  = full[7:0];
			fl   = '{z: (res == 8'h00), n: 1'b0, h: ((ai % 16) + (bi % 16) + ci > 15),
				c: (full > 255)};
		end
		alu_pkg::SUB, alu_pkg::SBC, alu_pkg::CP: begin
			if (op == alu_pkg::SBC) ci = f.c;
			full = ai - bi - ci;
			res  = (op == alu_pkg::CP) ? a : full[7:0];	// Compare keeps A
			fl   = '{z: (full[7:0] == 8'h00), n: 1'b1, h: ((ai % 16) < (bi % 16) + ci),
				c: (full < 0)};
		end
		alu_pkg::INC: begin
			res = a + 8'd1;
			fl  = '{z: (res == 8'h00), n: 1'b0, h: (a[3:0] == 4'hf), c: f.c};
		end
		alu_pkg::DEC: begin
			res = a - 8'd1;
			fl  = '{z: (res == 8'h00), n: 1'b1, h: (a[3:0] == 4'h0), c: f.c};
		end
		alu_pkg::AND: begin
			res = a & b;
			fl  = '{z: (res == 8'h00), n: 1'b0, h: 1'b1, c: 1'b0};
		end
		alu_pkg::OR, alu_pkg::XOR: begin
			res = (op == alu_pkg::OR) ? (a | b) : (a ^ b);
			fl  = '{z: (res == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
		end
		alu_pkg::RLC, alu_pkg::RRC, alu_pkg::RL, alu_pkg::RR,
		alu_pkg::SLA, alu_pkg::SRA, alu_pkg::SRL, alu_pkg::SWAP: begin
			case (op)
				alu_pkg::RLC: {fl.c, res} = {a[7], a[6:0], a[7]};
				alu_pkg::RRC: {res, fl.c} = {a[0], a[7:1], a[0]};
				alu_pkg::RL:  {fl.c, res} = {a, f.c};		// Old C enters
				alu_pkg::RR:  {res, fl.c} = {f.c, a};
				alu_pkg::SLA: {fl.c, res} = {a, 1'b0};
				alu_pkg::SRA: {res, fl.c} = {a[7], a};	// Sign stays
				alu_pkg::SRL: {res, fl.c} = {1'b0, a};
				default:      {res, fl.c} = {a[3:0], a[7:4], 1'b0};
			endcase
			fl.z = (res == 8'h00);
			fl.n = 1'b0;
			fl.h = 1'b0;
		end
		alu_pkg::DAA: begin
			if (f.h || (!f.n && a[3:0] > 4'd9)) corr = corr | 8'h06;
			if (f.c || (!f.n && a > 8'h99)) corr = corr | 8'h60;
			res  = f.n ? (a - corr) : (a + corr);
			fl.z = (res == 8'h00);
			fl.h = 1'b0;
			fl.c = (corr[7:4] != 4'h0);	// 60 applied
		end
		alu_pkg::CPL: begin
			res  = ~a;
			fl.n = 1'b1;
			fl.h = 1'b1;
		end
		alu_pkg::SCF, alu_pkg::CCF: begin
			fl.n = 1'b0;
			fl.h = 1'b0;
			fl.c = (op == alu_pkg::SCF) ? 1'b1 : ~f.c;
		end
		alu_pkg::BIT: fl = '{z: ~a[idx], n: 1'b0, h: 1'b1, c: f.c};
		alu_pkg::SET: res = a | (8'h01 << idx);
		alu_pkg::RES: res = a & ~(8'h01 << idx);
		default: ;
	endcase
endfunction

// Branch taken for a condition code and a set of flags
function automatic logic ref_cond(input alu_pkg::alu_cond_e cc, input alu_pkg::alu_flags_t f);
	case (cc)
		alu_pkg::NZ: return !f.z;
		alu_pkg::Z:  return f.z;
		alu_pkg::NC: return !f.c;
		default:     return f.c;
	endcase
endfunction

`endif

/* sim/tb_alu.sv */
`timescale 1ns/1ps
`include "alu_settings.svh"

module tb_alu;

	`include "tb_alu_ref.svh"

	localparam int          ack_timeout = 20;		// Cycles
	localparam logic [31:0] lfsr_taps   = 32'h80200003;
	localparam logic [1:0]  kind_data   = 2'd0;
	localparam logic [1:0]  kind_flags  = 2'd1;
	localparam logic [1:0]  kind_cond   = 2'd2;

	typedef struct packed {
		logic [1:0] kind;		// Which compare task
		logic [7:0] exp;
		logic [7:0] got;
	} cmp_item_t;

	logic             clk;
	logic             arst_n;
	alu_pkg::wb_m2s_t bus;
	alu_pkg::wb_s2m_t resp;
	logic [31:0]      lfsr_state = 32'hd48e290e;
	cmp_item_t        cmp_q[$];		// Pending compares
	string            name_q[$];

	alu_pkg::alu_op_e arith_ops [0:6] = '{alu_pkg::ADD, alu_pkg::ADC, alu_pkg::SUB,
		alu_pkg::SBC, alu_pkg::CP, alu_pkg::INC, alu_pkg::DEC};
	alu_pkg::alu_op_e logic_ops [0:5] = '{alu_pkg::AND, alu_pkg::OR, alu_pkg::XOR,
		alu_pkg::CPL, alu_pkg::SCF, alu_pkg::CCF};
	alu_pkg::alu_op_e shift_ops [0:7] = '{alu_pkg::RLC, alu_pkg::RRC, alu_pkg::RL,
		alu_pkg::RR, alu_pkg::SLA, alu_pkg::SRA, alu_pkg::SRL, alu_pkg::SWAP};
	alu_pkg::alu_op_e bit_ops [0:2]   = '{alu_pkg::BIT, alu_pkg::SET, alu_pkg::RES};

	alu_top alu_top_i (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (bus),
		.resp   (resp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;		// 40 ns period
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] val;
		logic       lsb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			lsb        = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) lfsr_state = lfsr_state ^ lfsr_taps;
			val = {val[6:0], lsb};
		end
		return val;
	endfunction

	task automatic fail_stop();
		$display("TB FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_data(input string name, input logic [7:0] exp, input logic [7:0] got);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected %02h got %02h", $time, name, exp, got);
			fail_stop();
		end
	endtask

	task automatic check_flags(input string name, input alu_pkg::alu_flags_t exp,
		input alu_pkg::alu_flags_t got);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected znhc=%b got znhc=%b",
				$time, name, exp, got);
			fail_stop();
		end
	endtask

	task automatic check_cond(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, name, exp, got);
			fail_stop();
		end
	endtask

	function automatic void post_compare(input logic [1:0] kind, input string name,
		input logic [7:0] exp, input logic [7:0] got);
		cmp_q.push_back('{kind: kind, exp: exp, got: got});
		name_q.push_back(name);
	endfunction

	// Compare process, drains everything the sequence has queued
	always @(negedge clk) begin : compare_proc
		cmp_item_t item;
		string     name;
		while (cmp_q.size() > 0) begin
			item = cmp_q.pop_front();
			name = name_q.pop_front();
			case (item.kind)
				kind_data:  check_data(name, item.exp, item.got);
				kind_flags: begin
					check_flags(name, alu_pkg::alu_flags_t'(item.exp[7:4]),
						alu_pkg::alu_flags_t'(item.got[7:4]));
					check_data({name, " low nibble"}, {4'h0, item.exp[3:0]},
						{4'h0, item.got[3:0]});	// Reads as zero
				end
				default: begin
					check_cond(name, item.exp[0], item.got[0]);
					check_data({name, " upper bits"}, {1'b0, item.exp[7:1]},
						{1'b0, item.got[7:1]});
				end
			endcase
		end
	end

	// Ack sampled on the falling edge, where it is stable
	task automatic wait_ack(input string what);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!resp.ack && cycles < ack_timeout);
		if (!resp.ack) begin
			$display("Bus %s at address %0d got no ack within %0d cycles",
				what, bus.adr, ack_timeout);
			fail_stop();
		end
	endtask

	task automatic wb_write(input logic [`ALU_WB_ADR_W-1:0] adr, input logic [7:0] dat);
		@(posedge clk);
		bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		wait_ack("write");
		@(posedge clk);		// Write lands here
		bus <= '0;
	endtask

	task automatic wb_read(input logic [`ALU_WB_ADR_W-1:0] adr, output logic [7:0] dat);
		@(posedge clk);
		bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
		wait_ack("read");
		dat = resp.dat;
		@(posedge clk);
		bus <= '0;
	endtask

	// Load operands and flags, launch, read back result and flags
	task automatic run_op(input alu_pkg::alu_op_e op, input logic [2:0] idx,
		input logic [7:0] a, input logic [7:0] b, input alu_pkg::alu_flags_t f,
		output logic [7:0] exp_res, output alu_pkg::alu_flags_t exp_fl);
		logic [7:0] got;
		ref_alu(op, idx, a, b, f, exp_res, exp_fl);
		wb_write(`ALU_ADR_OPA, a);
		wb_write(`ALU_ADR_OPB, b);
		wb_write(`ALU_ADR_FLAGS, {f, 4'h0});
		wb_write(`ALU_ADR_CTRL, {idx, op});
		wb_read(`ALU_ADR_RESULT, got);
		post_compare(kind_data, $sformatf("result (%s)", op.name()), exp_res, got);
		wb_read(`ALU_ADR_FLAGS, got);
		post_compare(kind_flags, $sformatf("flags (%s)", op.name()), {exp_fl, 4'h0}, got);
	endtask

	initial begin : sequence_proc
		logic [7:0]          a;
		logic [7:0]          b;
		logic [7:0]          got;
		logic [7:0]          res;
		alu_pkg::alu_flags_t f;
		alu_pkg::alu_flags_t fl;
		alu_pkg::alu_cond_e  cc;
		arst_n = 1'b0;
		bus    = '0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;

		// Reset values, condition NZ with Z clear is taken
		wb_read(`ALU_ADR_RESULT, got);
		post_compare(kind_data, "result after reset", 8'h00, got);
		wb_read(`ALU_ADR_FLAGS, got);
		post_compare(kind_flags, "flags after reset", 8'h00, got);
		wb_read(`ALU_ADR_OPA, got);
		post_compare(kind_data, "op_a after reset", 8'h00, got);
		wb_read(`ALU_ADR_OPB, got);
		post_compare(kind_data, "op_b after reset", 8'h00, got);
		wb_read(`ALU_ADR_COND, got);
		post_compare(kind_cond, "cond_taken after reset", ref_cond(alu_pkg::NZ, '0), got);

		for (int k = 0; k < 7; k++) begin
			repeat (16) begin
				a = rand_bits(8);
				b = rand_bits(8);
				f = alu_pkg::alu_flags_t'(rand_bits(4));
				run_op(arith_ops[k], 3'd0, a, b, f, res, fl);
			end
		end

		for (int k = 0; k < 6; k++) begin
			repeat (8) begin
				a = rand_bits(8);
				b = rand_bits(8);
				f = alu_pkg::alu_flags_t'(rand_bits(4));
				run_op(logic_ops[k], 3'd0, a, b, f, res, fl);
			end
		end

		for (int k = 0; k < 8; k++) begin
			for (int cin = 0; cin < 2; cin++) begin
				repeat (4) begin
					a = rand_bits(8);
					f = alu_pkg::alu_flags_t'({3'(rand_bits(3)), 1'(cin)});	// Incoming C fixed
					run_op(shift_ops[k], 3'd0, a, 8'h00, f, res, fl);
				end
			end
		end

		// BCD add or subtract, then DAA on its result and flags
		repeat (24) begin
			a = {4'(rand_bits(4) % 10), 4'(rand_bits(4) % 10)};
			b = {4'(rand_bits(4) % 10), 4'(rand_bits(4) % 10)};
			f = alu_pkg::alu_flags_t'(rand_bits(4));
			if (rand_bits(1)) run_op(alu_pkg::SUB, 3'd0, a, b, f, res, fl);
			else run_op(alu_pkg::ADD, 3'd0, a, b, f, res, fl);
			run_op(alu_pkg::DAA, 3'd0, res, 8'h00, fl, res, fl);
		end

		for (int k = 0; k < 3; k++) begin
			for (int i = 0; i < 8; i++) begin
				a = rand_bits(8);
				f = alu_pkg::alu_flags_t'(rand_bits(4));
				run_op(bit_ops[k], 3'(i), a, 8'h00, f, res, fl);
			end
		end

		for (int c = 0; c < 4; c++) begin
			cc = alu_pkg::alu_cond_e'(c);
			repeat (6) begin
				f = alu_pkg::alu_flags_t'(rand_bits(4));
				wb_write(`ALU_ADR_FLAGS, {f, 4'(rand_bits(4))});	// Low nibble ignored
				wb_write(`ALU_ADR_COND, {6'h00, 2'(c)});
				wb_read(`ALU_ADR_COND, got);
				post_compare(kind_cond, $sformatf("cond_taken (%s)", cc.name()),
					{7'h00, ref_cond(cc, f)}, got);
			end
		end

		repeat (2) @(posedge clk);		// Let the compare process drain
		if (cmp_q.size() == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("Compares were still pending at the end of the run");
			fail_stop();
		end
	end

endmodule
